/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -sv -Wno-fatal --top-module execUnit_tb \
		-Mdir obj_dir -f list.f
	./obj_dir/VexecUnit_tb > sim.log 2>&1; cat sim.log
	grep -q "^Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

/* alu/alu.sv */
`timescale 1ns/1ps

module alu
import wi23_defs::*;
(
   input  logic [REGFILE_WIDTH-1:0] A,
   input  logic [REGFILE_WIDTH-1:0] B,
   input  aluOpT                    Op,
   input  logic                     UnsignedOp,
   output logic [REGFILE_WIDTH-1:0] Out,
   output logic                     aluErr
);

   localparam int W = REGFILE_WIDTH;

   logic         invA;
   logic [W-1:0] aInv;
   logic [W:0]   sum;   // Carry in top bit
   logic [W-1:0] shft;
   logic         ofl;
   logic         eq, sle, slt;
   logic         usle, uslt;

   // Subtract and compare group inverts A so the adder gives B - A
   assign invA = Op[3] & Op[2];
   assign aInv = A ^ {W{invA}};
   assign sum  = {1'b0, aInv} + {1'b0, B} + {{W{1'b0}}, invA};

   shifter iShft (
      .In  (A),
      .Cnt (B[4:0]),
      .Op  (Op[1:0]),
      .Out (shft)
   );

   // Signed overflow of the add, used to correct the sign of B - A
   assign ofl = (sum[W-1] & ~aInv[W-1] & ~B[W-1]) | (~sum[W-1] & aInv[W-1] & B[W-1]);

   assign eq  = ~|sum[W-1:0];
   assign sle = ~sum[W-1] ^ ofl;   // B - A not negative
   assign slt = sle & ~eq;

   assign uslt = A < B;
   assign usle = uslt | (A == B);

   always_comb begin
      aluErr = 1'b0;
      casez (Op)
         5'b00000: Out = sum[W-1:0];   // ADD, ADDI
         5'b00010: Out = A ^ B;
         5'b00011: Out = A & ~B;
         5'b001??: Out = shft;         // Rotates and shifts
         5'b01001: Out = A;
         5'b01010: Out = B;            // LBI
         5'b01011: Out = (A << 16) | B;
         5'b01100: Out = {{(W-1){1'b0}}, eq};
         5'b01101: Out = {{(W-1){1'b0}}, UnsignedOp ? uslt : slt};
         5'b01110: Out = {{(W-1){1'b0}}, UnsignedOp ? usle : sle};
         5'b01111: Out = sum[W-1:0];   // SUB, SUBI
         5'b10010: Out = A | B;
         5'b10011: Out = A & B;
         default: begin
            aluErr = 1'b1;
            Out    = '0;
         end
      endcase
   end

endmodule

/* alu/shifter.sv */
`timescale 1ns/1ps

module shifter
import wi23_defs::*;
(
   input  logic [REGFILE_WIDTH-1:0] In,
   input  logic [4:0]               Cnt,
   input  logic [1:0]               Op,    // 00 rol, 01 sll, 10 ror, 11 srl
   output logic [REGFILE_WIDTH-1:0] Out
);

   localparam int W = REGFILE_WIDTH;

   logic [5:0][W-1:0] stage;

   assign stage[0] = In;

   // Stage i moves by 2**i when its count bit is set
   for (genvar i = 0; i < 5; i++) begin : gStage
      localparam int N = 1 << i;

      logic [W-1:0] rotL, shL, rotR, shR;

      assign rotL = {stage[i][W-N-1:0], stage[i][W-1:W-N]};
      assign shL  = {stage[i][W-N-1:0], {N{1'b0}}};
      assign rotR = {stage[i][N-1:0], stage[i][W-1:N]};
      assign shR  = {{N{1'b0}}, stage[i][W-1:N]};   // Logical, zero fill

      assign stage[i+1] = !Cnt[i]      ? stage[i] :
                          (Op == 2'b00) ? rotL :
                          (Op == 2'b01) ? shL :
                          (Op == 2'b10) ? rotR :
                                          shR;
   end

   assign Out = stage[5];

endmodule

/* common/wi23_defs.sv */
package wi23_defs;

   parameter int REGFILE_WIDTH = 32;   // Datapath width

   // Major opcodes in instr[15:11]
   typedef enum logic [4:0] {
      OP_ADDI   = 5'b01000,
      OP_SUBI   = 5'b01001,
      OP_XORI   = 5'b01010,
      OP_ANDNI  = 5'b01011,
      OP_SLBI   = 5'b10010,
      OP_ROLI   = 5'b10100,
      OP_SLLI   = 5'b10101,
      OP_RORI   = 5'b10110,
      OP_SRLI   = 5'b10111,
      OP_LBI    = 5'b11000,
      OP_SHIFTR = 5'b11010,   // Shift type in func
      OP_ARITHR = 5'b11011,   // Arithmetic type in func
      OP_SEQ    = 5'b11100,
      OP_SLT    = 5'b11101,
      OP_SLE    = 5'b11110
   } opcodeT;

   // ALU operation encodings, low two bits of the shift group go to the shifter
   typedef enum logic [4:0] {
      ALU_ADD   = 5'b00000,
      ALU_XOR   = 5'b00010,
      ALU_ANDN  = 5'b00011,
      ALU_ROL   = 5'b00100,
      ALU_SLL   = 5'b00101,
      ALU_ROR   = 5'b00110,
      ALU_SRL   = 5'b00111,
      ALU_PASSA = 5'b01001,   // Jump link value
      ALU_PASSB = 5'b01010,
      ALU_SLBI  = 5'b01011,
      ALU_SEQ   = 5'b01100,
      ALU_SLT   = 5'b01101,
      ALU_SLE   = 5'b01110,
      ALU_SUB   = 5'b01111,
      ALU_OR    = 5'b10010,
      ALU_AND   = 5'b10011
   } aluOpT;

   // Decoded instruction bundle from decode to execute and result
   typedef struct packed {
      logic                     valid;
      logic                     illegal;
      aluOpT                    aluOp;
      logic                     unsignedOp;   // Unsigned compare
      logic [REGFILE_WIDTH-1:0] opA;
      logic [REGFILE_WIDTH-1:0] opB;         // Register or immediate
   } decodedT;

endpackage

/* dv/execUnit_tb.sv */
`timescale 1ns/1ps

module execUnit_tb
import wi23_defs::*;
;

   localparam int W           = REGFILE_WIDTH;
   localparam int numDirected = 35;
   localparam int numRandom   = 300;
   localparam int numTests    = numDirected + numRandom;   // One clock per slot

   typedef struct packed {
      logic         ill;
      logic [W-1:0] res;
   } expectT;

   typedef struct packed {
      logic [15:0]  instr;
      logic [W-1:0] a;
      logic [W-1:0] b;
      logic [31:0]  cycle;   // Cycle count when driven
   } itemT;

   logic         clk, rstN, issue, resultValid, illegal;
   logic [15:0]  instr;
   logic [W-1:0] regA, regB, result;

   itemT   pending [$];
   itemT   item;
   expectT expected;
   int     cycle = 0;
   int     errors, checks;
   integer seed = 32'h765d9206;

   opcodeT opTable [15] = '{OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI, OP_SLBI, OP_ROLI, OP_SLLI,
                            OP_RORI, OP_SRLI, OP_LBI, OP_SHIFTR, OP_ARITHR, OP_SEQ, OP_SLT,
                            OP_SLE};

   tbClock iClock (.clk(clk), .rstN(rstN));

   execUnit dut (
      .clk         (clk),
      .rstN        (rstN),
      .issue       (issue),
      .instr       (instr),
      .regA        (regA),
      .regB        (regB),
      .result      (result),
      .resultValid (resultValid),
      .illegal     (illegal)
   );

   always @(posedge clk) cycle <= cycle + 1;

   function automatic logic [15:0] encode(input logic [4:0] op, input logic [10:0] rest);
      return {op, rest};
   endfunction

   // Kind 0 rol, 1 sll, 2 ror, 3 srl
   function automatic logic [W-1:0] shiftRef(input logic [W-1:0] x, input logic [4:0] n,
                                             input logic [1:0] kind);
      logic [2*W-1:0] t;
      case (kind)
         2'd0: begin
            t = {x, x} << n;
            return t[2*W-1:W];
         end
         2'd1: return x << n;
         2'd2: begin
            t = {x, x} >> n;
            return t[W-1:0];
         end
         default: return x >> n;
      endcase
   endfunction

   // Expected result and illegal flag from the instruction rules
   function automatic expectT refModel(input logic [15:0] ins, input logic [W-1:0] a,
                                       input logic [W-1:0] b);
      expectT       e;
      logic [1:0]   func;
      logic [W-1:0] imm5s, imm5z, imm8s, imm8z;
      logic         bit0;
      func  = ins[1:0];
      imm5s = {{(W-5){ins[4]}}, ins[4:0]};
      imm5z = {{(W-5){1'b0}}, ins[4:0]};
      imm8s = {{(W-8){ins[7]}}, ins[7:0]};
      imm8z = {{(W-8){1'b0}}, ins[7:0]};
      e.ill = 1'b0;
      e.res = '0;
      bit0  = 1'b0;
      case (ins[15:11])
         OP_ADDI:  e.res = a + imm5s;
         OP_SUBI:  e.res = imm5s - a;   // Immediate minus Rs
         OP_XORI:  e.res = a ^ imm5z;
         OP_ANDNI: e.res = a & ~imm5z;
         OP_SLBI:  e.res = (a << 16) | imm8z;
         OP_ROLI:  e.res = shiftRef(a, ins[4:0], 2'd0);
         OP_SLLI:  e.res = shiftRef(a, ins[4:0], 2'd1);
         OP_RORI:  e.res = shiftRef(a, ins[4:0], 2'd2);
         OP_SRLI:  e.res = shiftRef(a, ins[4:0], 2'd3);
         OP_LBI:    e.res = imm8s;
         OP_SHIFTR: e.res = shiftRef(a, b[4:0], func);
         OP_ARITHR: begin
            case (func)
               2'd0:    e.res = a + b;
               2'd1:    e.res = b - a;   // Rt minus Rs
               2'd2:    e.res = a ^ b;
               default: e.res = a & ~b;
            endcase
         end
         OP_SEQ, OP_SLT, OP_SLE: begin
            if (func[1]) begin
               e.ill = 1'b1;
            end else begin
               if (ins[15:11] == OP_SEQ) begin
                  bit0 = (a == b);
               end else if (ins[15:11] == OP_SLT) begin
                  bit0 = func[0] ? (a < b) : ($signed(a) < $signed(b));
               end else begin
                  bit0 = func[0] ? (a <= b) : ($signed(a) <= $signed(b));
               end
               e.res = {{(W-1){1'b0}}, bit0};
            end
         end
         default: e.ill = 1'b1;
      endcase
      return e;
   endfunction

   task automatic driveSlot(input logic doIssue, input logic [15:0] ins,
                            input logic [W-1:0] a, input logic [W-1:0] b);
      itemT it;
      @(negedge clk);
      issue = doIssue;
      instr = ins;
      regA  = a;
      regB  = b;
      if (doIssue) begin
         it.instr = ins;
         it.a     = a;
         it.b     = b;
         it.cycle = cycle;
         pending.push_back(it);
      end
   endtask

   // Outputs are settled at the falling edge
   always @(negedge clk) begin
      if (rstN) begin
         if (resultValid) begin
            assert (pending.size() != 0) else begin
               errors++;
               $display("At %0t resultValid pulsed with no instruction in flight", $time);
            end
            if (pending.size() != 0) begin
               item     = pending.pop_front();
               expected = refModel(item.instr, item.a, item.b);
               checks++;
               assert (cycle == int'(item.cycle) + 2) else begin
                  errors++;
                  $display("error %0t: latency %0d cycles for instr %h", $time,
                           cycle - int'(item.cycle), item.instr);
               end
               assert (result === expected.res) else begin
                  errors++;
                  $display("error %0t: result %h, expected %h for instr %h a %h b %h",
                           $time, result, expected.res, item.instr, item.a, item.b);
               end
               assert (illegal === expected.ill) else begin
                  errors++;
                  $display("error %0t: illegal %b, expected %b for instr %h", $time,
                           illegal, expected.ill, item.instr);
               end
            end
         end else if (pending.size() > 0) begin
            assert (cycle < int'(pending[0].cycle) + 2) else begin
               errors++;
               $display("At %0t no result came for instr %h", $time, pending[0].instr);
               void'(pending.pop_front());
            end
         end
      end
   end

   initial begin
      #((numTests + 20) * 20);
      $display("Watchdog timeout, the run did not finish in time");
      $display("Something failed");
      $finish;
   end

   initial begin
      integer       r, r2;
      logic [4:0]   op;
      logic [W-1:0] a, b;
      issue  = 1'b0;
      instr  = '0;
      regA   = '0;
      regB   = '0;
      errors = 0;
      checks = 0;
      @(posedge rstN);
      assert (!resultValid && !illegal && result == '0) else begin
         errors++;
         $display("error %0t: outputs not cleared by reset", $time);
      end
      repeat (3) driveSlot(1'b0, 16'hffff, '1, '1);   // No valid expected
      driveSlot(1'b1, encode(OP_ARITHR, 11'd0), 32'h7fffffff, 32'h1);
      driveSlot(1'b1, encode(OP_ARITHR, 11'd0), 32'hffffffff, 32'h1);
      driveSlot(1'b1, encode(OP_ARITHR, 11'd1), 32'h5, 32'h3);
      driveSlot(1'b1, encode(OP_ARITHR, 11'd2), 32'hf0f0a5a5, 32'h0ff05a5a);
      driveSlot(1'b1, encode(OP_ARITHR, 11'd3), 32'hffff00ff, 32'h0f0f0f0f);
      driveSlot(1'b1, encode(OP_ADDI, 11'h01f), 32'h0, 32'h0);
      driveSlot(1'b1, encode(OP_SUBI, 11'h010), 32'h1, 32'h0);
      driveSlot(1'b1, encode(OP_XORI, 11'h01f), 32'hffff0000, 32'h0);
      driveSlot(1'b1, encode(OP_ANDNI, 11'h01f), 32'hffffffff, 32'h0);
      driveSlot(1'b1, encode(OP_ROLI, 11'h000), 32'h80000001, 32'h0);
      driveSlot(1'b1, encode(OP_ROLI, 11'h01f), 32'h80000001, 32'h0);
      driveSlot(1'b1, encode(OP_SRLI, 11'h01f), 32'h80000000, 32'h0);
      driveSlot(1'b1, encode(OP_RORI, 11'h001), 32'h1, 32'h0);
      driveSlot(1'b1, encode(OP_SHIFTR, 11'd1), 32'h12345678, 32'hffffffe0);
      driveSlot(1'b1, encode(OP_SHIFTR, 11'd2), 32'h12345678, 32'd31);
      driveSlot(1'b1, encode(OP_SHIFTR, 11'd3), 32'hfedcba98, 32'd31);
      driveSlot(1'b1, encode(OP_SEQ, 11'd0), 32'h80000000, 32'h80000000);
      driveSlot(1'b1, encode(OP_SEQ, 11'd0), 32'h1, 32'h2);
      driveSlot(1'b1, encode(OP_SLT, 11'd0), 32'h80000000, 32'h0);
      driveSlot(1'b1, encode(OP_SLT, 11'd1), 32'h80000000, 32'h0);
      driveSlot(1'b1, encode(OP_SLT, 11'd0), 32'h1, 32'hffffffff);
      driveSlot(1'b1, encode(OP_SLE, 11'd0), 32'h80000000, 32'h80000000);
      driveSlot(1'b1, encode(OP_SLE, 11'd1), 32'hffffffff, 32'h1);
      driveSlot(1'b1, encode(OP_SLT, 11'd0), 32'h80000000, 32'h80000000);
      driveSlot(1'b1, encode(OP_LBI, 11'h080), 32'h0, 32'h0);
      driveSlot(1'b1, encode(OP_LBI, 11'h07f), 32'hffffffff, 32'h0);
      driveSlot(1'b1, encode(OP_SLBI, 11'h0ef), 32'h1234abcd, 32'h0);
      driveSlot(1'b0, 16'h0000, '0, '0);
      driveSlot(1'b1, encode(5'b00000, 11'h7ff), 32'h5, 32'h6);   // Unknown opcodes
      driveSlot(1'b1, encode(5'b11111, 11'h7ff), 32'h5, 32'h6);
      driveSlot(1'b1, encode(OP_SEQ, 11'd2), 32'h7, 32'h7);       // Bad compare funcs
      driveSlot(1'b1, encode(OP_SLT, 11'd3), 32'h0, 32'h1);
      for (int i = 0; i < numRandom; i++) begin
         r  = $random(seed);
         r2 = $random(seed);
         op = (r[1:0] == 2'b00) ? r[20:16] : opTable[r[15:8] % 8'd15];
         a  = (r[27:25] == 3'b000) ? 32'h80000000 : $random(seed);
         b  = (r[24:23] == 2'b00) ? a : $random(seed);   // Equal operands now and then
         driveSlot(r[31:29] != 3'b000, {op, r2[10:0]}, a, b);
      end
      driveSlot(1'b0, 16'h0000, '0, '0);
      while (pending.size() != 0) @(negedge clk);
      repeat (2) @(negedge clk);   // Catch stray valid pulses
      $display("Results checked %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

/* dv/tbClock.sv */
`timescale 1ns/1ps

module tbClock (
   output logic clk,
   output logic rstN
);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;   // 20 ns period
   end

   initial begin
      rstN = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rstN = 1'b1;   // Released between edges
   end

endmodule

/* list.f */
common/wi23_defs.sv
alu/shifter.sv
alu/alu.sv
rtl/instrDecode.sv
rtl/resultStage.sv
rtl/execUnit.sv
dv/tbClock.sv
dv/execUnit_tb.sv

/* rtl/execUnit.sv */
`timescale 1ns/1ps

module execUnit
import wi23_defs::*;
(
   input  logic                     clk,
   input  logic                     rstN,
   input  logic                     issue,
   input  logic [15:0]              instr,
   input  logic [REGFILE_WIDTH-1:0] regA,
   input  logic [REGFILE_WIDTH-1:0] regB,
   output logic [REGFILE_WIDTH-1:0] result,
   output logic                     resultValid,
   output logic                     illegal
);

   decodedT                  decoded;
   logic [REGFILE_WIDTH-1:0] aluOut;
   logic                     aluErr;

   instrDecode iDecode (
      .clk     (clk),
      .rstN    (rstN),
      .issue   (issue),
      .instr   (instr),
      .regA    (regA),
      .regB    (regB),
      .decoded (decoded)
   );

   alu iAlu (
      .A          (decoded.opA),
      .B          (decoded.opB),
      .Op         (decoded.aluOp),
      .UnsignedOp (decoded.unsignedOp),
      .Out        (aluOut),
      .aluErr     (aluErr)
   );

   resultStage iResult (
      .clk         (clk),
      .rstN        (rstN),
      .decoded     (decoded),
      .aluOut      (aluOut),
      .aluErr      (aluErr),
      .result      (result),
      .resultValid (resultValid),
      .illegal     (illegal)
   );

endmodule

/* rtl/instrDecode.sv */
`timescale 1ns/1ps

module instrDecode
import wi23_defs::*;
(
   input  logic                     clk,
   input  logic                     rstN,
   input  logic                     issue,
   input  logic [15:0]              instr,
   input  logic [REGFILE_WIDTH-1:0] regA,
   input  logic [REGFILE_WIDTH-1:0] regB,
   output decodedT                  decoded
);

   opcodeT                   opcode;
   logic [1:0]               func;
   logic [REGFILE_WIDTH-1:0] sext5, zext5;
   logic [REGFILE_WIDTH-1:0] sext8, zext8;
   decodedT                  decodedNext;

   assign opcode = opcodeT'(instr[15:11]);
   assign func   = instr[1:0];

   assign sext5 = {{(REGFILE_WIDTH-5){instr[4]}}, instr[4:0]};
   assign zext5 = {{(REGFILE_WIDTH-5){1'b0}}, instr[4:0]};
   assign sext8 = {{(REGFILE_WIDTH-8){instr[7]}}, instr[7:0]};
   assign zext8 = {{(REGFILE_WIDTH-8){1'b0}}, instr[7:0]};

   always_comb begin
      decodedNext.valid      = issue;
      decodedNext.illegal    = 1'b0;
      decodedNext.aluOp      = ALU_ADD;
      decodedNext.unsignedOp = 1'b0;
      decodedNext.opA        = regA;
      decodedNext.opB        = regB;   // Register formats keep Rt
      case (opcode)
         OP_ADDI: begin
            decodedNext.opB = sext5;
         end
         OP_SUBI: begin
            decodedNext.aluOp = ALU_SUB;   // Immediate minus Rs
            decodedNext.opB   = sext5;
         end
         OP_XORI: begin
            decodedNext.aluOp = ALU_XOR;
            decodedNext.opB   = zext5;
         end
         OP_ANDNI: begin
            decodedNext.aluOp = ALU_ANDN;
            decodedNext.opB   = zext5;
         end
         OP_SLBI: begin
            decodedNext.aluOp = ALU_SLBI;
            decodedNext.opB   = zext8;
         end
         OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
            decodedNext.aluOp = aluOpT'({3'b001, instr[12:11]});   // Shift type from opcode
            decodedNext.opB   = zext5;
         end
         OP_LBI: begin
            decodedNext.aluOp = ALU_PASSB;
            decodedNext.opB   = sext8;
         end
         OP_SHIFTR: begin
            decodedNext.aluOp = aluOpT'({3'b001, func});
         end
         OP_ARITHR: begin
            case (func)
               2'b00:   decodedNext.aluOp = ALU_ADD;
               2'b01:   decodedNext.aluOp = ALU_SUB;   // Rt minus Rs
               2'b10:   decodedNext.aluOp = ALU_XOR;
               default: decodedNext.aluOp = ALU_ANDN;
            endcase
         end
         OP_SEQ, OP_SLT, OP_SLE: begin
            // Compare kind sits in the low opcode bits, func picks signedness
            decodedNext.aluOp      = aluOpT'({3'b011, instr[12:11]});
            decodedNext.unsignedOp = func[0];
            decodedNext.illegal    = func[1];
         end
         default: begin
            decodedNext.illegal = 1'b1;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         decoded <= '0;
      end else begin
         decoded <= decodedNext;   // Valid follows issue
      end
   end

   assert property (@(posedge clk) disable iff (!rstN) !$isunknown(decoded.valid))
      else $error("decoded.valid unknown after reset");

endmodule

/* rtl/resultStage.sv */
`timescale 1ns/1ps

module resultStage
import wi23_defs::*;
(
   input  logic                     clk,
   input  logic                     rstN,
   input  decodedT                  decoded,
   input  logic [REGFILE_WIDTH-1:0] aluOut,
   input  logic                     aluErr,
   output logic [REGFILE_WIDTH-1:0] result,
   output logic                     resultValid,
   output logic                     illegal
);

   logic bad;

   // Either the decoder rejected it or the ALU hit an unmapped code
   assign bad = decoded.illegal | aluErr;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         resultValid <= 1'b0;
         illegal     <= 1'b0;
         result      <= '0;
      end else begin
         resultValid <= decoded.valid;
         if (decoded.valid) begin
            illegal <= bad;
            result  <= bad ? '0 : aluOut;   // Illegal results read as zero
         end
      end
   end

   // Decoder only emits mapped ALU codes for legal instructions
   assert property (@(posedge clk) disable iff (!rstN)
                    decoded.valid && !decoded.illegal |-> !aluErr)
      else $error("ALU error on a legal instruction, op %0h", decoded.aluOp);

endmodule
